/* logic/id_pkg.sv */
package id_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    //////////////////////////////////////////////////////////////////////
    // instruction word
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // same 32 bits, read as register or immediate format.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    //////////////////////////////////////////////////////////////////////
    // opcodes and functions
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    //////////////////////////////////////////////////////////////////////
    // decode results
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_AND  = 8'h01,
        OP_OR   = 8'h02,
        OP_XOR  = 8'h03,
        OP_NOR  = 8'h04,
        OP_SLL  = 8'h05,
        OP_SRL  = 8'h06,
        OP_SRA  = 8'h07,
        OP_ADD  = 8'h08,
        OP_ADDU = 8'h09,
        OP_SUB  = 8'h0a,
        OP_SUBU = 8'h0b,
        OP_SLT  = 8'h0c,
        OP_SLTU = 8'h0d
    } op_e;

    typedef enum logic [2:0] {
        CAT_NONE  = 3'd0,
        CAT_LOGIC = 3'd1,
        CAT_SHIFT = 3'd2,
        CAT_ARITH = 3'd3
    } cat_e;

    typedef struct packed {
        logic      legal;
        op_e       op;
        cat_e      cat;
        logic      rd_en_a;
        reg_addr_t rd_addr_a;
        logic      rd_en_b;
        reg_addr_t rd_addr_b;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     imm;
    } decode_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        op_e       op;
        cat_e      cat;
        word_t     operand_a;
        word_t     operand_b;
        logic      wr_en;
        reg_addr_t wr_addr;
    } issue_t;

endpackage

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import id_pkg::*; (
    input  instr_t  instr,
    output decode_t dec
);

    always_comb begin
        logic form_rrr;
        logic form_shamt;
        logic form_imm;

        form_rrr   = 1'b0;
        form_shamt = 1'b0;
        form_imm   = 1'b0;

        dec           = '0;
        dec.op        = OP_NOP;
        dec.cat       = CAT_NONE;
        dec.rd_addr_a = instr.r.rs;
        dec.rd_addr_b = instr.r.rt;
        dec.wr_addr   = instr.r.rd;

        case (instr.r.opcode)
            OPC_SPECIAL: begin
                // three register forms.
                if (instr.r.shamt == 5'd0) begin
                    form_rrr = 1'b1;
                    case (instr.r.funct)
                        FN_AND:  begin dec.op = OP_AND;  dec.cat = CAT_LOGIC; end
                        FN_OR:   begin dec.op = OP_OR;   dec.cat = CAT_LOGIC; end
                        FN_XOR:  begin dec.op = OP_XOR;  dec.cat = CAT_LOGIC; end
                        FN_NOR:  begin dec.op = OP_NOR;  dec.cat = CAT_LOGIC; end
                        FN_SLLV: begin dec.op = OP_SLL;  dec.cat = CAT_SHIFT; end
                        FN_SRLV: begin dec.op = OP_SRL;  dec.cat = CAT_SHIFT; end
                        FN_SRAV: begin dec.op = OP_SRA;  dec.cat = CAT_SHIFT; end
                        FN_ADD:  begin dec.op = OP_ADD;  dec.cat = CAT_ARITH; end
                        FN_ADDU: begin dec.op = OP_ADDU; dec.cat = CAT_ARITH; end
                        FN_SUB:  begin dec.op = OP_SUB;  dec.cat = CAT_ARITH; end
                        FN_SUBU: begin dec.op = OP_SUBU; dec.cat = CAT_ARITH; end
                        FN_SLT:  begin dec.op = OP_SLT;  dec.cat = CAT_ARITH; end
                        FN_SLTU: begin dec.op = OP_SLTU; dec.cat = CAT_ARITH; end
                        default: form_rrr = 1'b0;
                    endcase
                end

                // shift by shamt, rs field must be zero.
                if (instr.r.rs == 5'd0) begin
                    form_shamt = 1'b1;
                    case (instr.r.funct)
                        FN_SLL:  begin dec.op = OP_SLL; dec.cat = CAT_SHIFT; end
                        FN_SRL:  begin dec.op = OP_SRL; dec.cat = CAT_SHIFT; end
                        FN_SRA:  begin dec.op = OP_SRA; dec.cat = CAT_SHIFT; end
                        default: form_shamt = 1'b0;
                    endcase
                end
            end

            OPC_ANDI: begin
                form_imm = 1'b1;
                dec.op   = OP_AND;
                dec.cat  = CAT_LOGIC;
                dec.imm  = {16'b0, instr.i.imm};
            end
            OPC_ORI: begin
                form_imm = 1'b1;
                dec.op   = OP_OR;
                dec.cat  = CAT_LOGIC;
                dec.imm  = {16'b0, instr.i.imm};
            end
            OPC_XORI: begin
                form_imm = 1'b1;
                dec.op   = OP_XOR;
                dec.cat  = CAT_LOGIC;
                dec.imm  = {16'b0, instr.i.imm};
            end
            // or with rs, which is zero in a well formed lui.
            OPC_LUI: begin
                form_imm = 1'b1;
                dec.op   = OP_OR;
                dec.cat  = CAT_LOGIC;
                dec.imm  = {instr.i.imm, 16'b0};
            end
            OPC_ADDI: begin
                form_imm = 1'b1;
                dec.op   = OP_ADD;
                dec.cat  = CAT_ARITH;
                dec.imm  = {{16{instr.i.imm[15]}}, instr.i.imm};
            end
            OPC_ADDIU: begin
                form_imm = 1'b1;
                dec.op   = OP_ADDU;
                dec.cat  = CAT_ARITH;
                dec.imm  = {{16{instr.i.imm[15]}}, instr.i.imm};
            end
            OPC_SLTI: begin
                form_imm = 1'b1;
                dec.op   = OP_SLT;
                dec.cat  = CAT_ARITH;
                dec.imm  = {{16{instr.i.imm[15]}}, instr.i.imm};
            end
            OPC_SLTIU: begin
                form_imm = 1'b1;
                dec.op   = OP_SLTU;
                dec.cat  = CAT_ARITH;
                dec.imm  = {{16{instr.i.imm[15]}}, instr.i.imm};
            end
            default: begin
                form_imm = 1'b0;
            end
        endcase

        //////////////////////////////////////////////////////////////////
        // operand and write enables per form
        //////////////////////////////////////////////////////////////////

        if (form_rrr) begin
            dec.legal   = 1'b1;
            dec.rd_en_a = 1'b1;
            dec.rd_en_b = 1'b1;
            dec.wr_en   = 1'b1;
        end

        if (form_shamt) begin
            dec.legal   = 1'b1;
            dec.rd_en_b = 1'b1;
            dec.wr_en   = 1'b1;
            dec.imm     = {27'b0, instr.r.shamt};
        end

        if (form_imm) begin
            dec.legal   = 1'b1;
            dec.rd_en_a = 1'b1;
            dec.wr_en   = 1'b1;
            dec.wr_addr = instr.i.rt;
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import id_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_addr_t  rd_addr_a,
    output word_t      rd_data_a,
    input  reg_addr_t  rd_addr_b,
    output word_t      rd_data_b,
    input  reg_write_t wb
);

    // register 0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != 5'd0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // no write-through, the forwarding ports cover that case.
    always_comb begin
        if (rd_addr_a == 5'd0) begin
            rd_data_a = '0;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (rd_addr_b == 5'd0) begin
            rd_data_b = '0;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

endmodule

/* logic/operand_select.sv */
`timescale 1ns/1ps

module operand_select import id_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  decode_t    dec,
    input  word_t      rd_data_a,
    input  word_t      rd_data_b,
    input  reg_write_t ex_fwd,
    input  reg_write_t mem_fwd,
    output issue_t     issue
);

    word_t operand_a;
    word_t operand_b;
    logic  accept;

    // ex before mem before register file, immediate when not a read.
    function automatic word_t pick_operand(
        input logic       rd_en,
        input reg_addr_t  rd_addr,
        input word_t      rf_data,
        input word_t      imm,
        input reg_write_t ex_w,
        input reg_write_t mem_w
    );
        word_t result;

        if (rd_en && ex_w.en && (ex_w.addr == rd_addr) && (rd_addr != 5'd0)) begin
            result = ex_w.data;
        end else if (rd_en && mem_w.en && (mem_w.addr == rd_addr) && (rd_addr != 5'd0)) begin
            result = mem_w.data;
        end else if (rd_en) begin
            result = rf_data;
        end else begin
            result = imm;
        end
        return result;
    endfunction

    assign operand_a = pick_operand(dec.rd_en_a, dec.rd_addr_a, rd_data_a, dec.imm,
                                    ex_fwd, mem_fwd);
    assign operand_b = pick_operand(dec.rd_en_b, dec.rd_addr_b, rd_data_b, dec.imm,
                                    ex_fwd, mem_fwd);

    assign accept = in_valid && dec.legal;

    //////////////////////////////////////////////////////////////////////
    // id/ex register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            issue         <= '0;
            issue.op      <= OP_NOP;
            issue.cat     <= CAT_NONE;
        end else begin
            issue.valid     <= accept;
            issue.illegal   <= in_valid && !dec.legal;
            issue.op        <= dec.op;
            issue.cat       <= dec.cat;
            issue.operand_a <= operand_a;
            issue.operand_b <= operand_b;
            // only a live, legal instruction may request a write.
            issue.wr_en     <= dec.wr_en && accept;
            issue.wr_addr   <= dec.wr_addr;
        end
    end

endmodule

/* logic/stage_id.sv */
`timescale 1ns/1ps

module stage_id import id_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  instr_t     instr,
    input  logic       in_valid,
    input  reg_write_t wb,
    input  reg_write_t ex_fwd,
    input  reg_write_t mem_fwd,
    output issue_t     issue
);

    decode_t dec;
    word_t   rd_data_a;
    word_t   rd_data_b;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    //////////////////////////////////////////////////////////////////////
    // register read
    //////////////////////////////////////////////////////////////////////

    register_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (dec.rd_addr_a),
        .rd_data_a (rd_data_a),
        .rd_addr_b (dec.rd_addr_b),
        .rd_data_b (rd_data_b),
        .wb        (wb)
    );

    // bypass, immediate and issue register.
    operand_select u_opsel (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .dec       (dec),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .issue     (issue)
    );

endmodule

/* verif/stage_id_sva.sv */
`timescale 1ns/1ps

module stage_id_sva import id_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    in_valid,
    input decode_t dec,
    input issue_t  issue
);

    a_one_kind: assert property (@(posedge clk) disable iff (rst)
        !(issue.valid && issue.illegal))
        else $error("issue valid and illegal both high");

    a_wr_needs_valid: assert property (@(posedge clk) disable iff (rst)
        issue.wr_en |-> issue.valid)
        else $error("issue wr_en high without valid");

    // bundle empty right after a reset cycle.
    a_reset_clear: assert property (@(posedge clk)
        rst |=> (!issue.valid && !issue.illegal && !issue.wr_en))
        else $error("issue bundle not cleared after reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (issue.valid == $past(in_valid && dec.legal)))
        else $error("issue valid does not follow in_valid and legal");

endmodule

bind operand_select stage_id_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .dec      (dec),
    .issue    (issue)
);

/* verif/tb_stage_id.sv */
`timescale 1ns/1ps

module tb_stage_id import id_pkg::*; ();

    typedef enum logic [1:0] {SEL_EX, SEL_MEM, SEL_REG, SEL_IMM} src_e;

    // one row of the stimulus table.
    typedef struct packed {
        instr_t     instr;
        logic       in_valid;
        reg_write_t ex_fwd;
        reg_write_t mem_fwd;
        op_e        op;
        cat_e       cat;
        reg_addr_t  wr_addr;
        src_e       sel_a;
        src_e       sel_b;
        word_t      imm;
    } entry_t;

    localparam word_t      EX_DATA  = 32'hee00_00e1;
    localparam word_t      MEM_DATA = 32'hdd00_00d2;
    localparam reg_write_t NO_FWD   = '0;
    localparam logic [5:0] FN_MULT  = 6'b011000;

    logic       clk;
    logic       rst;
    instr_t     instr;
    logic       in_valid;
    reg_write_t wb;
    reg_write_t ex_fwd;
    reg_write_t mem_fwd;
    issue_t     issue;

    entry_t tests [$];
    string  names [$];
    word_t  shadow [0:31];
    word_t  rng_state;
    logic   table_ready;

    stage_id u_dut (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .in_valid (in_valid),
        .wb       (wb),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .issue    (issue)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instr_t encode_r(input reg_addr_t rs, input reg_addr_t rt,
                                        input reg_addr_t rd, input logic [4:0] shamt,
                                        input logic [5:0] funct);
        instr_t w;
        w.r = '{opcode: OPC_SPECIAL, rs: rs, rt: rt, rd: rd, shamt: shamt, funct: funct};
        return w;
    endfunction

    function automatic instr_t encode_i(input logic [5:0] opc, input reg_addr_t rs,
                                        input reg_addr_t rt, input logic [15:0] imm);
        instr_t w;
        w.i = '{opcode: opc, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic reg_write_t make_fwd(input reg_addr_t addr, input word_t data);
        reg_write_t w;
        w = '{en: 1'b1, addr: addr, data: data};
        return w;
    endfunction

    task automatic add_entry(input string name, input instr_t ins, input logic v,
                             input reg_write_t ex_w, input reg_write_t mem_w,
                             input op_e op, input cat_e cat, input reg_addr_t wr_addr,
                             input src_e sel_a, input src_e sel_b, input word_t imm);
        entry_t e;
        e = '{ins, v, ex_w, mem_w, op, cat, wr_addr, sel_a, sel_b, imm};
        tests.push_back(e);
        names.push_back(name);
    endtask

    task automatic build_table();
        add_entry("and_rrr", encode_r(1, 2, 3, 0, FN_AND), 1, NO_FWD, NO_FWD,
                  OP_AND, CAT_LOGIC, 3, SEL_REG, SEL_REG, 0);
        add_entry("nor_rrr", encode_r(4, 5, 6, 0, FN_NOR), 1, NO_FWD, NO_FWD,
                  OP_NOR, CAT_LOGIC, 6, SEL_REG, SEL_REG, 0);
        add_entry("addu_rrr", encode_r(7, 8, 9, 0, FN_ADDU), 1, NO_FWD, NO_FWD,
                  OP_ADDU, CAT_ARITH, 9, SEL_REG, SEL_REG, 0);
        add_entry("sub_rrr", encode_r(10, 11, 12, 0, FN_SUB), 1, NO_FWD, NO_FWD,
                  OP_SUB, CAT_ARITH, 12, SEL_REG, SEL_REG, 0);
        add_entry("slt_rrr", encode_r(13, 14, 15, 0, FN_SLT), 1, NO_FWD, NO_FWD,
                  OP_SLT, CAT_ARITH, 15, SEL_REG, SEL_REG, 0);
        // immediate forms, zero, shifted and sign extension.
        add_entry("andi", encode_i(OPC_ANDI, 16, 17, 16'hf0f0), 1, NO_FWD, NO_FWD,
                  OP_AND, CAT_LOGIC, 17, SEL_REG, SEL_IMM, 32'h0000_f0f0);
        add_entry("ori", encode_i(OPC_ORI, 18, 19, 16'h8001), 1, NO_FWD, NO_FWD,
                  OP_OR, CAT_LOGIC, 19, SEL_REG, SEL_IMM, 32'h0000_8001);
        add_entry("xori", encode_i(OPC_XORI, 20, 21, 16'hffff), 1, NO_FWD, NO_FWD,
                  OP_XOR, CAT_LOGIC, 21, SEL_REG, SEL_IMM, 32'h0000_ffff);
        add_entry("lui", encode_i(OPC_LUI, 0, 22, 16'h1234), 1, NO_FWD, NO_FWD,
                  OP_OR, CAT_LOGIC, 22, SEL_REG, SEL_IMM, 32'h1234_0000);
        add_entry("addi_neg", encode_i(OPC_ADDI, 23, 24, 16'hfff6), 1, NO_FWD, NO_FWD,
                  OP_ADD, CAT_ARITH, 24, SEL_REG, SEL_IMM, 32'hffff_fff6);
        add_entry("sltiu_neg", encode_i(OPC_SLTIU, 25, 26, 16'h8000), 1, NO_FWD, NO_FWD,
                  OP_SLTU, CAT_ARITH, 26, SEL_REG, SEL_IMM, 32'hffff_8000);
        // shifts.
        add_entry("sll", encode_r(0, 27, 28, 4, FN_SLL), 1, NO_FWD, NO_FWD,
                  OP_SLL, CAT_SHIFT, 28, SEL_IMM, SEL_REG, 4);
        add_entry("srl", encode_r(0, 29, 30, 31, FN_SRL), 1, NO_FWD, NO_FWD,
                  OP_SRL, CAT_SHIFT, 30, SEL_IMM, SEL_REG, 31);
        add_entry("sra", encode_r(0, 31, 1, 1, FN_SRA), 1, NO_FWD, NO_FWD,
                  OP_SRA, CAT_SHIFT, 1, SEL_IMM, SEL_REG, 1);
        add_entry("sllv", encode_r(2, 3, 4, 0, FN_SLLV), 1, NO_FWD, NO_FWD,
                  OP_SLL, CAT_SHIFT, 4, SEL_REG, SEL_REG, 0);
        add_entry("srlv", encode_r(5, 6, 7, 0, FN_SRLV), 1, NO_FWD, NO_FWD,
                  OP_SRL, CAT_SHIFT, 7, SEL_REG, SEL_REG, 0);
        add_entry("srav", encode_r(8, 9, 10, 0, FN_SRAV), 1, NO_FWD, NO_FWD,
                  OP_SRA, CAT_SHIFT, 10, SEL_REG, SEL_REG, 0);
        // forwarding.
        add_entry("fwd_ex", encode_r(1, 2, 3, 0, FN_ADD), 1, make_fwd(1, EX_DATA), NO_FWD,
                  OP_ADD, CAT_ARITH, 3, SEL_EX, SEL_REG, 0);
        add_entry("fwd_mem", encode_r(1, 2, 3, 0, FN_OR), 1, make_fwd(5, EX_DATA),
                  make_fwd(2, MEM_DATA), OP_OR, CAT_LOGIC, 3, SEL_REG, SEL_MEM, 0);
        add_entry("fwd_both", encode_r(4, 4, 5, 0, FN_XOR), 1, make_fwd(4, EX_DATA),
                  make_fwd(4, MEM_DATA), OP_XOR, CAT_LOGIC, 5, SEL_EX, SEL_EX, 0);
        add_entry("fwd_zero", encode_r(0, 6, 7, 0, FN_SUBU), 1, make_fwd(0, EX_DATA),
                  make_fwd(0, MEM_DATA), OP_SUBU, CAT_ARITH, 7, SEL_REG, SEL_REG, 0);
        add_entry("fwd_imm", encode_i(OPC_ADDIU, 3, 4, 16'h0010), 1, make_fwd(4, EX_DATA),
                  NO_FWD, OP_ADDU, CAT_ARITH, 4, SEL_REG, SEL_IMM, 32'h10);
        add_entry("fwd_mem_shift", encode_r(0, 9, 10, 2, FN_SRL), 1, NO_FWD,
                  make_fwd(9, MEM_DATA), OP_SRL, CAT_SHIFT, 10, SEL_IMM, SEL_MEM, 2);
        // illegal words and an idle cycle.
        add_entry("mult", encode_r(1, 2, 0, 0, FN_MULT), 1, NO_FWD, NO_FWD,
                  OP_NOP, CAT_NONE, 0, SEL_IMM, SEL_IMM, 0);
        add_entry("bad_opcode", encode_i(6'b111111, 1, 2, 16'h1234), 1, NO_FWD, NO_FWD,
                  OP_NOP, CAT_NONE, 0, SEL_IMM, SEL_IMM, 0);
        add_entry("and_shamt", encode_r(1, 2, 3, 1, FN_AND), 1, NO_FWD, NO_FWD,
                  OP_NOP, CAT_NONE, 0, SEL_IMM, SEL_IMM, 0);
        add_entry("idle", encode_r(1, 2, 3, 0, FN_AND), 0, NO_FWD, NO_FWD,
                  OP_AND, CAT_LOGIC, 3, SEL_REG, SEL_REG, 0);
    endtask

    function automatic word_t expected_operand(input src_e sel, input reg_addr_t addr,
                                               input entry_t e);
        word_t v;
        case (sel)
            SEL_EX:  v = e.ex_fwd.data;
            SEL_MEM: v = e.mem_fwd.data;
            SEL_REG: v = shadow[addr];
            default: v = e.imm;
        endcase
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string reason);
        $display("RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", name, what, exp, act);
            stop_run("mismatch");
        end
    endtask

    task automatic check_op(input string name, input op_e exp, input op_e act);
        if (act !== exp) begin
            $display("Error: %s op expected %s (%h) actual %s (%h)",
                     name, exp.name(), exp, act.name(), act);
            stop_run("mismatch");
        end
    endtask

    task automatic check_cat(input string name, input cat_e exp, input cat_e act);
        if (act !== exp) begin
            $display("Error: %s cat expected %s (%h) actual %s (%h)",
                     name, exp.name(), exp, act.name(), act);
            stop_run("mismatch");
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Error: %s wr_addr expected %0d actual %0d", name, exp, act);
            stop_run("mismatch");
        end
    endtask

    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", name, what, exp, act);
            stop_run("mismatch");
        end
    endtask

    // a legal kept instruction always has a category and a write.
    task automatic check_entry(input int idx);
        entry_t e;
        logic   legal;
        logic   exp_valid;
        e         = tests[idx];
        legal     = (e.cat != CAT_NONE);
        exp_valid = e.in_valid && legal;
        check_bit(names[idx], "valid", exp_valid, issue.valid);
        check_bit(names[idx], "illegal", e.in_valid && !legal, issue.illegal);
        check_bit(names[idx], "wr_en", exp_valid, issue.wr_en);
        if (e.in_valid) begin
            check_op(names[idx], e.op, issue.op);
            check_cat(names[idx], e.cat, issue.cat);
        end
        if (exp_valid) begin
            check_addr(names[idx], e.wr_addr, issue.wr_addr);
            check_word(names[idx], "operand_a",
                       expected_operand(e.sel_a, e.instr.r.rs, e), issue.operand_a);
            check_word(names[idx], "operand_b",
                       expected_operand(e.sel_b, e.instr.r.rt, e), issue.operand_b);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = '0;
        in_valid    = 1'b0;
        wb          = '0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        shadow[0]   = '0;
        rng_state   = 32'd69;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // preload registers 1 to 31.
        for (int r = 1; r < 32; r++) begin
            rng_state = xorshift(rng_state);
            shadow[r] = rng_state;
            wb        = make_fwd(reg_addr_t'(r), rng_state);
            @(negedge clk);
        end
        wb = '0;

        // each row is checked one cycle after it is applied.
        for (int i = 0; i < tests.size(); i++) begin
            instr    = tests[i].instr;
            in_valid = tests[i].in_valid;
            ex_fwd   = tests[i].ex_fwd;
            mem_fwd  = tests[i].mem_fwd;
            @(negedge clk);
            check_entry(i);
        end
        in_valid = 1'b0;

        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((tests.size() + 31 + 20) * 20);
        $display("the run timed out before all table entries were checked");
        stop_run("timeout");
    end

endmodule

/* compile.f */
logic/id_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/operand_select.sv
logic/stage_id.sv
verif/stage_id_sva.sv
verif/tb_stage_id.sv

/* Bender.yml */
package:
  name: stage_id

sources:
  - files:
      - logic/id_pkg.sv
      - logic/instr_decoder.sv
      - logic/register_file.sv
      - logic/operand_select.sv
      - logic/stage_id.sv
  - target: test
    files:
      - verif/stage_id_sva.sv
      - verif/tb_stage_id.sv
